// ==== design/rv_isa_pkg.sv ====
`default_nettype none

package rv_isa_pkg;

	// major opcode shared by every register-register arithmetic instruction
	localparam logic [6:0] opcode_op = 7'b0110011;

	// funct7 is all zeros for the plain forms
	localparam logic [6:0] funct7_base = 7'b0000000;

	// bit 30 set turns ADD into SUB and SRL into SRA
	localparam logic [6:0] funct7_alt = 7'b0100000;

	// funct3 selects the operation family inside the group
	localparam logic [2:0] funct3_add_sub = 3'b000;
	localparam logic [2:0] funct3_sll = 3'b001;
	localparam logic [2:0] funct3_slt = 3'b010;
	localparam logic [2:0] funct3_sltu = 3'b011;
	localparam logic [2:0] funct3_xor = 3'b100;
	localparam logic [2:0] funct3_srl_sra = 3'b101;
	localparam logic [2:0] funct3_or = 3'b110;
	localparam logic [2:0] funct3_and = 3'b111;

	// only the low bits of rs2 count as a shift amount on RV32
	localparam int shamt_w = 5;

	typedef enum logic [3:0] {
		op_add,
		op_sub,
		op_and,
		op_or,
		op_xor,
		op_sll,
		op_srl,
		op_sra,
		op_slt,
		op_sltu,
		op_illegal
	} alu_op_e;

endpackage

`default_nettype wire

// ==== design/exec_cfg_pkg.sv ====
`default_nettype none

package exec_cfg_pkg;

	// lanes are filled and drained round-robin, so this stays a power of two
	localparam int num_lanes = 4;
	localparam int lane_idx_w = $clog2(num_lanes);

	localparam int xlen = 32;

	// architectural register index width
	localparam int reg_idx_w = 5;

	// one finished instruction as it leaves a lane
	typedef struct packed {
		logic [xlen-1:0] result;
		logic [reg_idx_w-1:0] rd;
		logic illegal;
	} exec_result_t;

endpackage

`default_nettype wire

// ==== design/issue_if.sv ====
`timescale 1ns/1ns
`default_nettype none

interface issue_if;
	import exec_cfg_pkg::*;

	logic valid;
	logic ready;
	logic [31:0] instr;
	logic [xlen-1:0] rs1_value;
	logic [xlen-1:0] rs2_value;

	// the dispatcher side
	modport source (
		output valid,
		output instr,
		output rs1_value,
		output rs2_value,
		input ready
	);

	// the lane side
	modport sink (
		input valid,
		input instr,
		input rs1_value,
		input rs2_value,
		output ready
	);

endinterface

`default_nettype wire

// ==== design/result_if.sv ====
`timescale 1ns/1ns
`default_nettype none

interface result_if;
	import exec_cfg_pkg::*;

	logic valid;
	logic ready;
	exec_result_t data;

	// the lane side
	modport source (
		output valid,
		output data,
		input ready
	);

	// the collector side
	modport sink (
		input valid,
		input data,
		output ready
	);

endinterface

`default_nettype wire

// ==== design/issue_dispatch.sv ====
`timescale 1ns/1ns
`default_nettype none

module issue_dispatch (
	input wire clock,
	input wire reset,
	input wire in_valid,
	input wire [31:0] instr,
	input wire [exec_cfg_pkg::xlen-1:0] rs1_value,
	input wire [exec_cfg_pkg::xlen-1:0] rs2_value,
	output logic in_ready,
	issue_if.source lanes [exec_cfg_pkg::num_lanes]
);
	import exec_cfg_pkg::*;

	logic [lane_idx_w-1:0] ptr;
	logic [num_lanes-1:0] lane_sel;
	logic [num_lanes-1:0] lane_ready;
	logic accept;

	// interface arrays only take constant indices, so each lane gets its own slice
	for (genvar i = 0; i < num_lanes; i++) begin : lane_steer
		assign lane_sel[i] = (ptr == lane_idx_w'(i));
		assign lane_ready[i] = lanes[i].ready;

		assign lanes[i].valid = in_valid && lane_sel[i];
		assign lanes[i].instr = lane_sel[i] ? instr : '0;
		assign lanes[i].rs1_value = lane_sel[i] ? rs1_value : '0;
		assign lanes[i].rs2_value = lane_sel[i] ? rs2_value : '0;
	end

	// the upstream sees exactly the readiness of the lane whose turn it is
	assign in_ready = lane_ready[ptr];
	assign accept = in_valid && in_ready;

	always_ff @(posedge clock) begin
		if (reset) begin
			ptr <= '0;
		end else if (accept) begin
			if (ptr == lane_idx_w'(num_lanes - 1)) begin
				ptr <= '0;
			end else begin
				ptr <= ptr + 1'b1;
			end
		end
	end

endmodule

`default_nettype wire

// ==== design/rtype_lane.sv ====
`timescale 1ns/1ns
`default_nettype none

module rtype_lane (
	input wire clock,
	input wire reset,
	issue_if.sink issue,
	result_if.source result
);
	import rv_isa_pkg::*;
	import exec_cfg_pkg::*;

	logic [6:0] opcode;
	logic [2:0] funct3;
	logic [6:0] funct7;
	logic is_base;
	logic is_alt;
	alu_op_e dec_op;

	logic s1_valid;
	alu_op_e s1_op;
	logic [xlen-1:0] s1_a;
	logic [xlen-1:0] s1_b;
	logic [reg_idx_w-1:0] s1_rd;

	logic s2_valid;
	exec_result_t s2_data;
	exec_result_t s2_next;
	logic [xlen-1:0] alu_value;
	logic [shamt_w-1:0] shamt;

	logic accept;
	logic s1_move;
	logic s2_free;

	assign opcode = issue.instr[6:0];
	assign funct3 = issue.instr[14:12];
	assign funct7 = issue.instr[31:25];
	assign is_base = (funct7 == funct7_base);
	assign is_alt = (funct7 == funct7_alt);

	// only ADD/SUB and SRL/SRA accept the alternate funct7
	always_comb begin
		dec_op = op_illegal;
		if (opcode == opcode_op) begin
			case (funct3)
				funct3_add_sub: dec_op = is_base ? op_add : (is_alt ? op_sub : op_illegal);
				funct3_srl_sra: dec_op = is_base ? op_srl : (is_alt ? op_sra : op_illegal);
				funct3_sll: dec_op = is_base ? op_sll : op_illegal;
				funct3_slt: dec_op = is_base ? op_slt : op_illegal;
				funct3_sltu: dec_op = is_base ? op_sltu : op_illegal;
				funct3_xor: dec_op = is_base ? op_xor : op_illegal;
				funct3_or: dec_op = is_base ? op_or : op_illegal;
				funct3_and: dec_op = is_base ? op_and : op_illegal;
				default: dec_op = op_illegal;
			endcase
		end
	end

	assign shamt = s1_b[shamt_w-1:0];

	always_comb begin
		case (s1_op)
			op_add: alu_value = s1_a + s1_b;
			op_sub: alu_value = s1_a - s1_b;
			op_and: alu_value = s1_a & s1_b;
			op_or: alu_value = s1_a | s1_b;
			op_xor: alu_value = s1_a ^ s1_b;
			op_sll: alu_value = s1_a << shamt;
			op_srl: alu_value = s1_a >> shamt;
			op_sra: alu_value = xlen'($signed(s1_a) >>> shamt);
			op_slt: alu_value = {{(xlen-1){1'b0}}, $signed(s1_a) < $signed(s1_b)};
			op_sltu: alu_value = {{(xlen-1){1'b0}}, s1_a < s1_b};
			default: alu_value = '0;
		endcase
	end

	// writes to x0 are discarded, so the visible result is zero
	always_comb begin
		s2_next.illegal = (s1_op == op_illegal);
		s2_next.rd = s1_rd;
		s2_next.result = (s2_next.illegal || s1_rd == '0) ? '0 : alu_value;
	end

	assign s2_free = !s2_valid || result.ready;
	assign s1_move = s1_valid && s2_free;
	assign issue.ready = !s1_valid || s2_free;
	assign accept = issue.valid && issue.ready;

	assign result.valid = s2_valid;
	assign result.data = s2_data;

	always_ff @(posedge clock) begin
		if (reset) begin
			s1_valid <= 1'b0;
			s2_valid <= 1'b0;
		end else begin
			if (accept) begin
				s1_valid <= 1'b1;
			end else if (s1_move) begin
				s1_valid <= 1'b0;
			end
			if (s1_move) begin
				s2_valid <= 1'b1;
			end else if (result.ready) begin
				s2_valid <= 1'b0;
			end
		end
	end

	always_ff @(posedge clock) begin
		if (accept) begin
			s1_op <= dec_op;
			s1_a <= issue.rs1_value;
			s1_b <= issue.rs2_value;
			s1_rd <= issue.instr[11:7];
		end
		if (s1_move) begin
			s2_data <= s2_next;
		end
	end

endmodule

`default_nettype wire

// ==== design/result_collector.sv ====
`timescale 1ns/1ns
`default_nettype none

module result_collector (
	input wire clock,
	input wire reset,
	input wire out_ready,
	result_if.sink lanes [exec_cfg_pkg::num_lanes],
	output logic out_valid,
	output exec_cfg_pkg::exec_result_t out_data
);
	import exec_cfg_pkg::*;

	logic [lane_idx_w-1:0] ptr;
	logic [num_lanes-1:0] lane_valid;
	exec_result_t lane_data [num_lanes];
	logic take_ready;
	logic take;

	// the output register can refill in the same cycle it is drained
	assign take_ready = !out_valid || out_ready;

	for (genvar i = 0; i < num_lanes; i++) begin : lane_drain
		assign lanes[i].ready = take_ready && (ptr == lane_idx_w'(i));
		assign lane_valid[i] = lanes[i].valid;
		assign lane_data[i] = lanes[i].data;
	end

	// waiting on the lane at the pointer keeps results in issue order
	assign take = take_ready && lane_valid[ptr];

	always_ff @(posedge clock) begin
		if (reset) begin
			ptr <= '0;
			out_valid <= 1'b0;
		end else begin
			if (take) begin
				out_valid <= 1'b1;
				if (ptr == lane_idx_w'(num_lanes - 1)) begin
					ptr <= '0;
				end else begin
					ptr <= ptr + 1'b1;
				end
			end else if (out_ready) begin
				out_valid <= 1'b0;
			end
		end
	end

	always_ff @(posedge clock) begin
		if (take) begin
			out_data <= lane_data[ptr];
		end
	end

endmodule

`default_nettype wire

// ==== design/rtype_exec_top.sv ====
`timescale 1ns/1ns
`default_nettype none

module rtype_exec_top (
	input wire clock,
	input wire reset,
	input wire in_valid,
	input wire [31:0] instr,
	input wire [exec_cfg_pkg::xlen-1:0] rs1_value,
	input wire [exec_cfg_pkg::xlen-1:0] rs2_value,
	input wire out_ready,
	output logic in_ready,
	output logic out_valid,
	output logic [exec_cfg_pkg::xlen-1:0] out_result,
	output logic [exec_cfg_pkg::reg_idx_w-1:0] out_rd,
	output logic out_illegal
);
	import exec_cfg_pkg::*;

	issue_if issue_bus [num_lanes] ();
	result_if result_bus [num_lanes] ();
	exec_result_t out_data;

	issue_dispatch u_dispatch (
		.clock(clock),
		.reset(reset),
		.in_valid(in_valid),
		.instr(instr),
		.rs1_value(rs1_value),
		.rs2_value(rs2_value),
		.in_ready(in_ready),
		.lanes(issue_bus)
	);

	for (genvar i = 0; i < num_lanes; i++) begin : lane_gen
		rtype_lane u_lane (
			.clock(clock),
			.reset(reset),
			.issue(issue_bus[i]),
			.result(result_bus[i])
		);
	end

	result_collector u_collector (
		.clock(clock),
		.reset(reset),
		.out_ready(out_ready),
		.lanes(result_bus),
		.out_valid(out_valid),
		.out_data(out_data)
	);

	assign out_result = out_data.result;
	assign out_rd = out_data.rd;
	assign out_illegal = out_data.illegal;

endmodule

`default_nettype wire

// ==== verif/rtype_exec_tb.sv ====
`timescale 1ns/1ns
`default_nettype none

module rtype_exec_tb;

	localparam int num_entries = 24;
	localparam int max_cycles = num_entries * 12 + 50;
	// the acceptance cycle counts as the first one
	localparam int isolated_latency = 3;
	localparam int stall_cycles = 3;
	localparam logic [6:0] op_rtype = 7'b0110011;

	logic clock;
	logic reset;
	logic in_valid;
	logic [31:0] instr;
	logic [31:0] rs1_value;
	logic [31:0] rs2_value;
	logic out_ready;
	wire in_ready;
	wire out_valid;
	wire [31:0] out_result;
	wire [4:0] out_rd;
	wire out_illegal;

	logic [31:0] table_instr [num_entries];
	logic [31:0] table_a [num_entries];
	logic [31:0] table_b [num_entries];
	logic table_stall [num_entries];

	integer seed;
	integer cycle_count = 0;
	integer pass_count = 0;
	integer fail_count = 0;
	integer test_errors = 0;
	logic saw_backpressure = 1'b0;

	rtype_exec_top UUT (
		.clock(clock),
		.reset(reset),
		.in_valid(in_valid),
		.instr(instr),
		.rs1_value(rs1_value),
		.rs2_value(rs2_value),
		.out_ready(out_ready),
		.in_ready(in_ready),
		.out_valid(out_valid),
		.out_result(out_result),
		.out_rd(out_rd),
		.out_illegal(out_illegal)
	);

	initial clock = 1'b0;
	always #4 clock = ~clock;

	always @(posedge clock) begin
		cycle_count = cycle_count + 1;
		if (cycle_count >= max_cycles) begin
			$display("Timeout after %0d cycles, an expected output never arrived", cycle_count);
			$display("Simulation failed");
			$finish;
		end
	end

	// inputs settle 1 ns after the edge, so the falling edge sees a stable handshake
	always @(negedge clock) begin
		if (!reset && in_valid && !in_ready) begin
			saw_backpressure <= 1'b1;
		end
	end

	function automatic logic [31:0] rtype(input logic [6:0] f7, input logic [2:0] f3,
			input logic [4:0] rd, input int idx);
		return {f7, 5'(idx + 3), 5'(idx), f3, rd, op_rtype};
	endfunction

	// returns {result, rd, illegal}
	function automatic logic [37:0] expected_of(input logic [31:0] word,
			input logic [31:0] a, input logic [31:0] b);
		logic [6:0] f7;
		logic [2:0] f3;
		logic [4:0] sh;
		logic legal;
		logic [31:0] value;
		f7 = word[31:25];
		f3 = word[14:12];
		sh = b[4:0];
		legal = (word[6:0] == op_rtype) &&
			(f7 == 7'h00 || (f7 == 7'h20 && (f3 == 3'd0 || f3 == 3'd5)));
		case (f3)
			3'd0: value = f7[5] ? a - b : a + b;
			3'd1: value = a << sh;
			3'd2: value = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
			3'd3: value = (a < b) ? 32'd1 : 32'd0;
			3'd4: value = a ^ b;
			3'd5: begin
				if (f7[5]) begin
					value = $signed(a) >>> sh;
				end else begin
					value = a >> sh;
				end
			end
			3'd6: value = a | b;
			default: value = a & b;
		endcase
		if (!legal || word[11:7] == 5'd0) begin
			value = 32'd0;
		end
		return {value, word[11:7], !legal};
	endfunction

	task automatic set_entry(input int idx, input logic [31:0] word, input logic [31:0] a,
			input logic [31:0] b, input logic stall);
		table_instr[idx] = word;
		table_a[idx] = a;
		table_b[idx] = b;
		table_stall[idx] = stall;
	endtask

	task automatic fill_table();
		set_entry(0, rtype(7'h00, 3'd0, 5'd1, 0), $random(seed), $random(seed), 1'b0);
		set_entry(1, rtype(7'h20, 3'd0, 5'd2, 1), $random(seed), $random(seed), 1'b0);
		set_entry(2, rtype(7'h00, 3'd7, 5'd3, 2), $random(seed), $random(seed), 1'b0);
		set_entry(3, rtype(7'h00, 3'd6, 5'd4, 3), $random(seed), $random(seed), 1'b0);
		set_entry(4, rtype(7'h00, 3'd4, 5'd5, 4), $random(seed), $random(seed), 1'b0);
		// only the low 5 bits of rs2 are a shift amount
		set_entry(5, rtype(7'h00, 3'd1, 5'd6, 5), $random(seed), 32'hffff_ffe4, 1'b0);
		set_entry(6, rtype(7'h00, 3'd5, 5'd7, 6), 32'h8000_0000, 32'h0000_0021, 1'b0);
		set_entry(7, rtype(7'h20, 3'd5, 5'd8, 7), 32'h8765_4321, 32'h0000_0004, 1'b0);
		set_entry(8, rtype(7'h00, 3'd2, 5'd9, 8), 32'hffff_fffe, 32'h0000_0001, 1'b0);
		set_entry(9, rtype(7'h00, 3'd3, 5'd10, 9), 32'hffff_fffe, 32'h0000_0001, 1'b0);
		// a run of stalls slows the drain to one result in four cycles
		set_entry(10, rtype(7'h00, 3'd2, 5'd11, 10), 32'd5, 32'hffff_fffd, 1'b1);
		set_entry(11, rtype(7'h00, 3'd3, 5'd12, 11), 32'd5, 32'hffff_fffd, 1'b1);
		set_entry(12, rtype(7'h00, 3'd0, 5'd0, 12), $random(seed), $random(seed), 1'b1);
		// flipping bit 5 turns the opcode into OP-IMM
		set_entry(13, rtype(7'h00, 3'd0, 5'd13, 13) ^ 32'h20, 32'd7, 32'd9, 1'b1);
		set_entry(14, rtype(7'h01, 3'd0, 5'd14, 14), $random(seed), $random(seed), 1'b1);
		set_entry(15, rtype(7'h20, 3'd1, 5'd15, 15), $random(seed), 32'd3, 1'b1);
		set_entry(16, rtype(7'h20, 3'd5, 5'd16, 16), 32'hffff_ffff, 32'd31, 1'b0);
		set_entry(17, rtype(7'h20, 3'd0, 5'd17, 17), 32'd0, 32'd1, 1'b0);
		set_entry(18, rtype(7'h00, 3'd4, 5'd18, 18), $random(seed), $random(seed), 1'b0);
		set_entry(19, rtype(7'h00, 3'd0, 5'd19, 19), 32'h7fff_ffff, 32'd1, 1'b0);
		set_entry(20, rtype(7'h00, 3'd5, 5'd20, 20), $random(seed), $random(seed), 1'b0);
		set_entry(21, rtype(7'h00, 3'd6, 5'd21, 21), $random(seed), $random(seed), 1'b0);
		set_entry(22, rtype(7'h00, 3'd3, 5'd22, 22), $random(seed), $random(seed), 1'b1);
		set_entry(23, rtype(7'h00, 3'd7, 5'd31, 23), $random(seed), $random(seed), 1'b0);
	endtask

	task automatic check_field(input string name, input logic [31:0] expected,
			input logic [31:0] actual);
		if (actual !== expected) begin
			$display("Fail time=%0t signal=%s expected=%h got=%h", $time, name, expected, actual);
			test_errors = test_errors + 1;
		end
	endtask

	task automatic check_output(input logic [37:0] expected);
		check_field("out_result", expected[37:6], out_result);
		check_field("out_rd", {27'd0, expected[5:1]}, {27'd0, out_rd});
		check_field("out_illegal", {31'd0, expected[0]}, {31'd0, out_illegal});
	endtask

	task automatic report_test(input string label);
		if (test_errors == 0) begin
			pass_count = pass_count + 1;
			$display("test %s: ok", label);
		end else begin
			fail_count = fail_count + 1;
			$display("test %s: FAILED with %0d errors", label, test_errors);
		end
		test_errors = 0;
	endtask

	task automatic send(input logic [31:0] word, input logic [31:0] a, input logic [31:0] b);
		logic accepted;
		in_valid = 1'b1;
		instr = word;
		rs1_value = a;
		rs2_value = b;
		accepted = 1'b0;
		while (!accepted) begin
			@(negedge clock);
			accepted = in_ready;
			@(posedge clock);
			#1;
		end
		in_valid = 1'b0;
	endtask

	task automatic check_isolated();
		logic [31:0] word;
		logic seen;
		int cycles;
		word = rtype(7'h00, 3'd0, 5'd17, 30);
		send(word, 32'h0000_1234, 32'h0000_4321);
		cycles = 0;
		seen = 1'b0;
		while (!seen) begin
			@(negedge clock);
			cycles = cycles + 1;
			seen = out_valid;
			if (seen) begin
				check_output(expected_of(word, 32'h0000_1234, 32'h0000_4321));
			end
			@(posedge clock);
			#1;
		end
		check_field("latency", isolated_latency, cycles);
		report_test("isolated latency");
	endtask

	task automatic drive_entries();
		int i;
		for (i = 0; i < num_entries; i++) begin
			send(table_instr[i], table_a[i], table_b[i]);
		end
	endtask

	task automatic collect_entries();
		int i;
		logic seen;
		for (i = 0; i < num_entries; i++) begin
			seen = 1'b0;
			while (!seen) begin
				@(negedge clock);
				seen = out_valid;
				if (seen) begin
					check_output(expected_of(table_instr[i], table_a[i], table_b[i]));
				end
				@(posedge clock);
				#1;
			end
			report_test($sformatf("entry %0d", i));
			if (table_stall[i]) begin
				out_ready = 1'b0;
				repeat (stall_cycles) @(posedge clock);
				#1;
				out_ready = 1'b1;
			end
		end
	endtask

	initial begin
		seed = 32'h28c68219;
		reset = 1'b1;
		in_valid = 1'b0;
		instr = 32'd0;
		rs1_value = 32'd0;
		rs2_value = 32'd0;
		out_ready = 1'b1;
		fill_table();
		repeat (8) @(posedge clock);
		#1;
		reset = 1'b0;

		@(negedge clock);
		check_field("out_valid", 32'd0, {31'd0, out_valid});
		check_field("in_ready", 32'd1, {31'd0, in_ready});
		report_test("idle after reset");
		@(posedge clock);
		#1;

		check_isolated();
		fork
			drive_entries();
			collect_entries();
		join

		repeat (10) begin
			@(negedge clock);
			if (out_valid) begin
				$display("Extra output seen after the last table entry at time %0t", $time);
				test_errors = test_errors + 1;
			end
		end
		report_test("no extra output");
		if (!saw_backpressure) begin
			$display("in_ready never fell while the output was stalled");
			test_errors = test_errors + 1;
		end
		report_test("back-pressure");

		$display("tests passed: %0d, tests failed: %0d", pass_count, fail_count);
		if (fail_count == 0) begin
			$display("Simulation completed successfully");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== rtype_exec_top.f ====
design/rv_isa_pkg.sv
design/exec_cfg_pkg.sv
design/issue_if.sv
design/result_if.sv
design/issue_dispatch.sv
design/rtype_lane.sv
design/result_collector.sv
design/rtype_exec_top.sv
verif/rtype_exec_tb.sv

// ==== Makefile ====
TOP = rtype_exec_tb

.PHONY: sim clean

sim:
	verilator --binary --timing --top-module $(TOP) -f rtype_exec_top.f -o $(TOP)
	./obj_dir/$(TOP) | tee /dev/stderr | grep -q "Simulation completed successfully"

clean:
	rm -rf obj_dir
